// ==== logic/ntt_bf_if.sv ====
// ------------------------------------------------------------
// Butterfly operand bundle
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface ntt_bf_if;
    import ntt_field_pkg::*;
    import ntt_mode_pkg::*;

    // Sampled by the butterfly on every clock
    coeff_t u;
    coeff_t v;
    coeff_t w;
    mode_t  mode;
    logic   accumulate;

    modport src (
        output u,
        output v,
        output w,
        output mode,
        output accumulate
    );

    modport dst (
        input u,
        input v,
        input w,
        input mode,
        input accumulate
    );

endinterface

`default_nettype wire

// ==== logic/ntt_butterfly.sv ====
// ------------------------------------------------------------
// NTT butterfly unit with point-wise modes
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ntt_butterfly (
    input  wire                   clk,
    input  wire                   reset_n,
    input  wire                   zeroize_i,
    ntt_bf_if.dst                 bf,
    output ntt_field_pkg::coeff_t u_o,
    output ntt_field_pkg::coeff_t v_o,
    output ntt_field_pkg::coeff_t pwo_o
);
    import ntt_field_pkg::*;
    import ntt_mode_pkg::*;

    // ------------------------------------------------------------
    // Modular add and subtract, inputs below q
    // ------------------------------------------------------------
    function automatic coeff_t mod_add(coeff_t a, coeff_t b);
        logic [COEFF_W:0] s;
        logic [COEFF_W:0] t;
        s = {1'b0, a} + {1'b0, b};
        t = s - {1'b0, Q};
        return (s >= {1'b0, Q}) ? t[COEFF_W-1:0] : s[COEFF_W-1:0];
    endfunction

    function automatic coeff_t mod_sub(coeff_t a, coeff_t b);
        logic [COEFF_W:0] d;
        logic [COEFF_W:0] t;
        d = {1'b0, a} - {1'b0, b};
        t = d + {1'b0, Q};
        return (a >= b) ? d[COEFF_W-1:0] : t[COEFF_W-1:0];
    endfunction

    // gs operands, registered one cycle ahead of the multiplier
    coeff_t w_r;
    coeff_t diff_r;

    // Carries u (ct), u + v (gs) or the accumulate term (pwm)
    coeff_t dl [MULT_LATENCY];
    coeff_t dl_in;

    coeff_t mult_a;
    coeff_t mult_b;
    coeff_t mult_p;

    coeff_t u_r;
    coeff_t v_r;
    coeff_t pwo_r;
    coeff_t pw_r;

    always_comb begin
        case (bf.mode)
            ct: begin
                mult_a = bf.w;
                mult_b = bf.v;
                dl_in  = bf.u;
            end
            gs: begin
                mult_a = w_r;
                mult_b = diff_r;
                dl_in  = mod_add(bf.u, bf.v);
            end
            pwm: begin
                mult_a = bf.u;
                mult_b = bf.v;
                dl_in  = bf.accumulate ? bf.w : '0;
            end
            default: begin
                mult_a = '0;
                mult_b = '0;
                dl_in  = '0;
            end
        endcase
    end

    ntt_mod_mult u_mult (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (mult_a),
        .b_i       (mult_b),
        .p_o       (mult_p)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            w_r    <= '0;
            diff_r <= '0;
            for (int i = 0; i < MULT_LATENCY; i++) begin
                dl[i] <= '0;
            end
        end else if (zeroize_i) begin
            w_r    <= '0;
            diff_r <= '0;
            for (int i = 0; i < MULT_LATENCY; i++) begin
                dl[i] <= '0;
            end
        end else begin
            w_r    <= bf.w;
            diff_r <= mod_sub(bf.u, bf.v);
            dl[0]  <= dl_in;
            for (int i = 1; i < MULT_LATENCY; i++) begin
                dl[i] <= dl[i-1];
            end
        end
    end

    // ------------------------------------------------------------
    // Output stage
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            u_r   <= '0;
            v_r   <= '0;
            pwo_r <= '0;
            pw_r  <= '0;
        end else if (zeroize_i) begin
            u_r   <= '0;
            v_r   <= '0;
            pwo_r <= '0;
            pw_r  <= '0;
        end else begin
            // gs sum is already reduced, it only needs the last delay
            u_r   <= (bf.mode == ct) ? mod_add(dl[MULT_LATENCY-1], mult_p)
                                     : dl[MULT_LATENCY-1];
            v_r   <= mod_sub(dl[MULT_LATENCY-1], mult_p);
            pwo_r <= mod_add(mult_p, dl[MULT_LATENCY-1]);
            // Single-cycle add/subtract path
            pw_r  <= (bf.mode == pws) ? mod_sub(bf.u, bf.v) : mod_add(bf.u, bf.v);
        end
    end

    assign u_o = u_r;
    // gs product leaves the multiplier register directly
    assign v_o   = (bf.mode == gs) ? mult_p : v_r;
    assign pwo_o = (bf.mode inside {pwa, pws}) ? pw_r : pwo_r;

endmodule

`default_nettype wire

// ==== logic/ntt_butterfly_2x2.sv ====
// ------------------------------------------------------------
// NTT 2x2 butterfly array
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ntt_butterfly_2x2 (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire                        zeroize_i,
    input  wire                        enable_i,
    input  wire                        accumulate_i,
    input  ntt_mode_pkg::mode_t        mode_i,
    input  ntt_field_pkg::coeff_pair_t bf_u_i,
    input  ntt_field_pkg::coeff_pair_t bf_v_i,
    input  ntt_field_pkg::coeff_quad_t bf_w_i,
    input  ntt_field_pkg::coeff_quad_t pw_u_i,
    input  ntt_field_pkg::coeff_quad_t pw_v_i,
    input  ntt_field_pkg::coeff_quad_t pw_w_i,
    output ntt_field_pkg::coeff_quad_t bf_uv_o,
    output ntt_field_pkg::coeff_quad_t pwo_o,
    output logic                       ready_o
);
    import ntt_field_pkg::*;
    import ntt_mode_pkg::*;

    // Butterflies 0 and 1 form stage 1, 2 and 3 form stage 2
    ntt_bf_if bf_if [4] ();

    coeff_t bf_u_out [4];
    coeff_t bf_v_out [4];
    coeff_t bf_pwo   [4];

    coeff_t tr_u [4];
    coeff_t tr_v [4];
    coeff_t tr_w [4];

    coeff_t w2_dly [BF_LATENCY];
    coeff_t w3_dly [BF_LATENCY];

    logic pw_mode;

    logic [ARRAY_LATENCY-1:0] rdy_sr;
    logic [ARRAY_LATENCY-1:0] rdy_next;

    assign pw_mode = mode_i inside {pwm, pwa, pws};

    // ------------------------------------------------------------
    // Stage-2 twiddle delay, matches one butterfly latency
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < BF_LATENCY; i++) begin
                w2_dly[i] <= '0;
                w3_dly[i] <= '0;
            end
        end else if (zeroize_i) begin
            for (int i = 0; i < BF_LATENCY; i++) begin
                w2_dly[i] <= '0;
                w3_dly[i] <= '0;
            end
        end else begin
            w2_dly[0] <= bf_w_i[2*COEFF_W +: COEFF_W];
            w3_dly[0] <= bf_w_i[3*COEFF_W +: COEFF_W];
            for (int i = 1; i < BF_LATENCY; i++) begin
                w2_dly[i] <= w2_dly[i-1];
                w3_dly[i] <= w3_dly[i-1];
            end
        end
    end

    // Transform routing, stage 2 crosses the stage-1 outputs
    always_comb begin
        tr_u[0] = bf_u_i[0 +: COEFF_W];
        tr_v[0] = bf_v_i[0 +: COEFF_W];
        tr_w[0] = bf_w_i[0 +: COEFF_W];

        tr_u[1] = bf_u_i[COEFF_W +: COEFF_W];
        tr_v[1] = bf_v_i[COEFF_W +: COEFF_W];
        tr_w[1] = bf_w_i[COEFF_W +: COEFF_W];

        tr_u[2] = bf_u_out[0];
        tr_v[2] = bf_u_out[1];
        tr_w[2] = w2_dly[BF_LATENCY-1];

        tr_u[3] = bf_v_out[0];
        tr_v[3] = bf_v_out[1];
        tr_w[3] = w3_dly[BF_LATENCY-1];
    end

    // ------------------------------------------------------------
    // Operand steering and butterfly instances
    // ------------------------------------------------------------
    for (genvar k = 0; k < 4; k++) begin : g_bf
        assign bf_if[k].u = pw_mode ? pw_u_i[k*COEFF_W +: COEFF_W] : tr_u[k];
        assign bf_if[k].v = pw_mode ? pw_v_i[k*COEFF_W +: COEFF_W] : tr_v[k];
        assign bf_if[k].w = pw_mode ? pw_w_i[k*COEFF_W +: COEFF_W] : tr_w[k];
        assign bf_if[k].mode       = mode_i;
        assign bf_if[k].accumulate = accumulate_i;

        ntt_butterfly u_bf (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize_i),
            .bf        (bf_if[k]),
            .u_o       (bf_u_out[k]),
            .v_o       (bf_v_out[k]),
            .pwo_o     (bf_pwo[k])
        );

        assign pwo_o[k*COEFF_W +: COEFF_W] = bf_pwo[k];
    end

    assign bf_uv_o = {bf_v_out[3], bf_u_out[3], bf_v_out[2], bf_u_out[2]};

    // ------------------------------------------------------------
    // Ready tracking
    // ------------------------------------------------------------
    // Enable enters at the mode's depth and walks down to bit 0
    always_comb begin
        rdy_next = rdy_sr >> 1;
        case (mode_i)
            ct, gs: begin
                rdy_next[ARRAY_LATENCY-1] = rdy_next[ARRAY_LATENCY-1] | enable_i;
            end
            pwm: begin
                rdy_next[BF_LATENCY-1] = rdy_next[BF_LATENCY-1] | enable_i;
            end
            pwa, pws: begin
                rdy_next[ADD_LATENCY-1] = rdy_next[ADD_LATENCY-1] | enable_i;
            end
            default: begin
                rdy_next = rdy_sr >> 1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rdy_sr <= '0;
        end else if (zeroize_i) begin
            rdy_sr <= '0;
        end else begin
            rdy_sr <= rdy_next;
        end
    end

    assign ready_o = rdy_sr[0];

endmodule

`default_nettype wire

// ==== logic/ntt_field_pkg.sv ====
// ------------------------------------------------------------
// NTT coefficient field definitions
// ------------------------------------------------------------
`default_nettype none

package ntt_field_pkg;

    // Field of the lattice scheme, q = 2^23 - 2^13 + 1
    localparam int COEFF_W = 23;

    typedef logic [COEFF_W-1:0]   coeff_t;
    typedef logic [2*COEFF_W-1:0] prod_t;

    // Packed lanes, lane 0 in the low bits
    typedef logic [2*COEFF_W-1:0] coeff_pair_t;
    typedef logic [4*COEFF_W-1:0] coeff_quad_t;

    localparam coeff_t Q = 23'd8380417;

    // ------------------------------------------------------------
    // Barrett reduction, m = floor(2^k / q)
    // ------------------------------------------------------------
    localparam int BARRETT_K = 46;
    localparam logic [23:0] BARRETT_M = 24'd8396807;

endpackage

`default_nettype wire

// ==== logic/ntt_mod_mult.sv ====
// ------------------------------------------------------------
// Pipelined Barrett modular multiplier
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ntt_mod_mult (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  zeroize_i,
    input  ntt_field_pkg::coeff_t a_i,
    input  ntt_field_pkg::coeff_t b_i,
    output ntt_field_pkg::coeff_t p_o
);
    import ntt_field_pkg::*;

    prod_t  prod_r;
    coeff_t qhat_r;
    // Remainder is below 2q, so 24 low bits are enough
    logic [COEFF_W:0] lo_r;
    coeff_t p_r;

    logic [BARRETT_K+COEFF_W:0] bar_full;
    coeff_t                     qhat;
    prod_t                      qq;
    logic [COEFF_W:0]           rem;
    logic [COEFF_W:0]           rem_sub;
    coeff_t                     p_next;

    // Quotient estimate, never above the true quotient and at most one below
    always_comb begin
        bar_full = prod_r * BARRETT_M;
        qhat     = bar_full[BARRETT_K +: COEFF_W];
    end

    always_comb begin
        qq      = qhat_r * Q;
        rem     = lo_r - qq[COEFF_W:0];
        rem_sub = rem - {1'b0, Q};
        // Single correction step
        if (rem >= {1'b0, Q}) begin
            p_next = rem_sub[COEFF_W-1:0];
        end else begin
            p_next = rem[COEFF_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_r <= '0;
            qhat_r <= '0;
            lo_r   <= '0;
            p_r    <= '0;
        end else if (zeroize_i) begin
            prod_r <= '0;
            qhat_r <= '0;
            lo_r   <= '0;
            p_r    <= '0;
        end else begin
            // Stage 1 full product
            prod_r <= a_i * b_i;
            // Stage 2 quotient estimate and low bits
            qhat_r <= qhat;
            lo_r   <= prod_r[COEFF_W:0];
            // Stage 3 reduced result
            p_r    <= p_next;
        end
    end

    assign p_o = p_r;

endmodule

`default_nettype wire

// ==== logic/ntt_mode_pkg.sv ====
// ------------------------------------------------------------
// NTT operation modes and latencies
// ------------------------------------------------------------
`default_nettype none

package ntt_mode_pkg;

    typedef enum logic [2:0] {
        ct  = 3'd0,
        gs  = 3'd1,
        pwm = 3'd2,
        pwa = 3'd3,
        pws = 3'd4
    } mode_t;

    // Pipeline depths in clock cycles
    localparam int MULT_LATENCY  = 3;
    localparam int BF_LATENCY    = 4;
    localparam int ADD_LATENCY   = 1;
    localparam int ARRAY_LATENCY = 2 * BF_LATENCY;

endpackage

`default_nettype wire

// ==== sim.f ====
logic/ntt_field_pkg.sv
logic/ntt_mode_pkg.sv
logic/ntt_bf_if.sv
logic/ntt_mod_mult.sv
logic/ntt_butterfly.sv
logic/ntt_butterfly_2x2.sv
sim/ntt_butterfly_2x2_chk.sv
sim/ntt_butterfly_2x2_tb.sv

// ==== sim/ntt_butterfly_2x2_chk.sv ====
// ------------------------------------------------------------
// NTT array timing assertions
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ntt_butterfly_2x2_chk (
    input wire                 clk,
    input wire                 reset_n,
    input wire                 zeroize_i,
    input wire                 enable_i,
    input ntt_mode_pkg::mode_t mode_i,
    input wire                 ready_o
);
    import ntt_mode_pkg::*;

    // No result while reset is held
    a_reset_quiet: assert property (@(posedge clk) !reset_n |-> !ready_o)
        else $error("ready_o high during reset");

    a_zeroize_flush: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize_i |=> !ready_o)
        else $error("ready_o high after zeroize");

    // Forward transform runs through both stages
    a_ct_latency: assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        (enable_i && mode_i == ct) |-> ##ARRAY_LATENCY ready_o)
        else $error("ct result missing after array latency");

endmodule

bind ntt_butterfly_2x2 ntt_butterfly_2x2_chk u_chk (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize_i (zeroize_i),
    .enable_i  (enable_i),
    .mode_i    (mode_i),
    .ready_o   (ready_o)
);

`default_nettype wire

// ==== sim/ntt_butterfly_2x2_tb.sv ====
// ------------------------------------------------------------
// NTT 2x2 butterfly array testbench
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ntt_butterfly_2x2_tb;
    import ntt_field_pkg::*;
    import ntt_mode_pkg::*;

    logic        clk;
    logic        reset_n;
    logic        zeroize;
    logic        enable;
    logic        accumulate;
    mode_t       mode;
    coeff_pair_t bf_u;
    coeff_pair_t bf_v;
    coeff_quad_t bf_w;
    coeff_quad_t pw_u;
    coeff_quad_t pw_v;
    coeff_quad_t pw_w;
    coeff_quad_t bf_uv;
    coeff_quad_t pwo;
    logic        ready;

    logic [31:0] lcg_state = 32'h6439_d0b8;
    int          cyc = 0;
    coeff_quad_t exp_q [$];
    mode_t       mode_q [$];
    int          cyc_q [$];

    ntt_butterfly_2x2 dut_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize),
        .enable_i     (enable),
        .accumulate_i (accumulate),
        .mode_i       (mode),
        .bf_u_i       (bf_u),
        .bf_v_i       (bf_v),
        .bf_w_i       (bf_w),
        .pw_u_i       (pw_u),
        .pw_v_i       (pw_v),
        .pw_w_i       (pw_w),
        .bf_uv_o      (bf_uv),
        .pwo_o        (pwo),
        .ready_o      (ready)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic coeff_t rand_coeff();
        return coeff_t'(lcg_next() % Q);
    endfunction

    // ------------------------------------------------------------
    // Reference model in plain modular arithmetic
    // ------------------------------------------------------------
    function automatic coeff_t fadd(coeff_t a, coeff_t b);
        return coeff_t'((longint'(a) + longint'(b)) % longint'(Q));
    endfunction

    function automatic coeff_t fsub(coeff_t a, coeff_t b);
        return coeff_t'((longint'(a) + longint'(Q) - longint'(b)) % longint'(Q));
    endfunction

    function automatic coeff_t fmul(coeff_t a, coeff_t b);
        return coeff_t'((longint'(a) * longint'(b)) % longint'(Q));
    endfunction

    function automatic void bfly(input mode_t m, input coeff_t a, input coeff_t b,
                                 input coeff_t w, output coeff_t x, output coeff_t y);
        coeff_t t;
        if (m == ct) begin
            t = fmul(w, b);
            x = fadd(a, t);
            y = fsub(a, t);
        end else begin
            x = fadd(a, b);
            y = fmul(fsub(a, b), w);
        end
    endfunction

    function automatic coeff_quad_t ref_2x2(input mode_t m, input bit acc);
        coeff_t      u1 [2];
        coeff_t      v1 [2];
        coeff_t      r [4];
        coeff_t      a;
        coeff_t      b;
        coeff_t      c;
        coeff_quad_t res;
        if (m inside {ct, gs}) begin
            for (int k = 0; k < 2; k++) begin
                bfly(m, bf_u[k*COEFF_W +: COEFF_W], bf_v[k*COEFF_W +: COEFF_W],
                     bf_w[k*COEFF_W +: COEFF_W], u1[k], v1[k]);
            end
            bfly(m, u1[0], u1[1], bf_w[2*COEFF_W +: COEFF_W], r[0], r[1]);
            bfly(m, v1[0], v1[1], bf_w[3*COEFF_W +: COEFF_W], r[2], r[3]);
        end else begin
            for (int k = 0; k < 4; k++) begin
                a = pw_u[k*COEFF_W +: COEFF_W];
                b = pw_v[k*COEFF_W +: COEFF_W];
                c = pw_w[k*COEFF_W +: COEFF_W];
                case (m)
                    pwm:     r[k] = fadd(fmul(a, b), acc ? c : coeff_t'(0));
                    pwa:     r[k] = fadd(a, b);
                    default: r[k] = fsub(a, b);
                endcase
            end
        end
        res = {r[3], r[2], r[1], r[0]};
        return res;
    endfunction

    // ------------------------------------------------------------
    // Failure reporting and compare tasks
    // ------------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at first failure");
    endtask

    task automatic check_quad(input coeff_quad_t got, input coeff_quad_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t: bf_uv_o is %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_pwo(input coeff_quad_t got, input coeff_quad_t exp);
        for (int k = 0; k < 4; k++) begin
            if (got[k*COEFF_W +: COEFF_W] !== exp[k*COEFF_W +: COEFF_W]) begin
                abort_run($sformatf("[ERROR] %0t: pwo_o lane %0d is %h, expected %h", $time,
                          k, got[k*COEFF_W +: COEFF_W], exp[k*COEFF_W +: COEFF_W]));
            end
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("[ERROR] %0t: ready_o after %0d cycles, expected %0d",
                      $time, got, exp));
        end
    endtask

    // Outputs are read at the rising edge before the DUT updates them
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (reset_n && ready) begin
            if (exp_q.size() == 0) begin
                abort_run("ready_o pulsed while no operation was in flight");
            end else begin
                case (mode_q[0])
                    ct, gs:  check_latency(cyc - cyc_q[0], ARRAY_LATENCY + 1);
                    pwm:     check_latency(cyc - cyc_q[0], BF_LATENCY + 1);
                    default: check_latency(cyc - cyc_q[0], ADD_LATENCY + 1);
                endcase
                if (mode_q[0] inside {ct, gs}) begin
                    check_quad(bf_uv, exp_q[0]);
                end else begin
                    check_pwo(pwo, exp_q[0]);
                end
                void'(exp_q.pop_front());
                void'(mode_q.pop_front());
                void'(cyc_q.pop_front());
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    // sel 1 all zero, 2 all q-1, 3 wrap-around pair, else random
    task automatic issue_op(input mode_t m, input bit acc, input int sel);
        coeff_t a;
        coeff_t b;
        @(negedge clk);
        for (int k = 0; k < 4; k++) begin
            case (sel)
                1: begin
                    a = '0;
                    b = '0;
                end
                2: begin
                    a = Q - 1;
                    b = Q - 1;
                end
                3: begin
                    a = '0;
                    b = Q - 1;
                end
                default: begin
                    a = rand_coeff();
                    b = rand_coeff();
                end
            endcase
            pw_u[k*COEFF_W +: COEFF_W] = a;
            pw_v[k*COEFF_W +: COEFF_W] = b;
            pw_w[k*COEFF_W +: COEFF_W] = (sel == 2) ? Q - 1 : rand_coeff();
            bf_w[k*COEFF_W +: COEFF_W] = (sel == 2) ? Q - 1 : rand_coeff();
            if (k < 2) begin
                bf_u[k*COEFF_W +: COEFF_W] = a;
                bf_v[k*COEFF_W +: COEFF_W] = b;
            end
        end
        mode       = m;
        accumulate = acc;
        enable     = 1'b1;
        exp_q.push_back(ref_2x2(m, acc));
        mode_q.push_back(m);
        cyc_q.push_back(cyc);
    endtask

    task automatic wait_drain(input string what);
        for (int t = 0; t < 100 && exp_q.size() != 0; t++) begin
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            abort_run($sformatf("Timeout: the %s result never arrived", what));
        end
    endtask

    task automatic run_burst(input mode_t m, input bit acc, input int n, input bit edges);
        for (int i = 0; i < n; i++) begin
            issue_op(m, acc, edges ? (i % 4) : 0);
        end
        @(negedge clk);
        enable = 1'b0;
        wait_drain(m.name());
    endtask

    initial begin
        clk        = 1'b0;
        reset_n    = 1'b0;
        zeroize    = 1'b0;
        enable     = 1'b0;
        accumulate = 1'b0;
        mode       = ct;
        bf_u       = '0;
        bf_v       = '0;
        bf_w       = '0;
        pw_u       = '0;
        pw_v       = '0;
        pw_w       = '0;
        repeat (4) @(negedge clk);
        reset_n = 1'b1;

        run_burst(ct, 1'b0, 50, 1'b0);
        run_burst(gs, 1'b0, 50, 1'b1);
        run_burst(pwm, 1'b0, 20, 1'b1);
        run_burst(pwm, 1'b1, 20, 1'b1);
        run_burst(pwa, 1'b0, 20, 1'b1);
        run_burst(pws, 1'b0, 20, 1'b1);

        // Zeroize lands just as the first of seven ct items is due to report
        for (int i = 0; i < 7; i++) begin
            issue_op(ct, 1'b0, 0);
        end
        @(negedge clk);
        enable  = 1'b0;
        zeroize = 1'b1;
        exp_q.delete();
        mode_q.delete();
        cyc_q.delete();
        @(negedge clk);
        zeroize = 1'b0;
        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
        end
        run_burst(ct, 1'b0, 1, 1'b0);

        // Mode changes between drained bursts
        run_burst(pwm, 1'b1, 5, 1'b0);
        run_burst(gs, 1'b0, 5, 1'b0);
        run_burst(pwa, 1'b0, 5, 1'b0);
        run_burst(ct, 1'b0, 5, 1'b0);
        run_burst(pws, 1'b0, 5, 1'b0);
        run_burst(pwm, 1'b0, 5, 1'b0);

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
